/* Bender.yml */
package:
  name: mem_game

sources:
  - files:
      - hw/bomb_pkg.sv
      - hw/mem_puzzle_gen.sv
      - hw/mem_cursor.sv
      - hw/mem_select_detector.sv
      - hw/mem_strike_tracker.sv
      - hw/mem_game.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/mem_game_checker.sv
      - test/mem_game_assert.sv
      - test/tb_mem_game.sv

/* hw/bomb_pkg.sv */
// shared constants for the bomb game board
// puzzle select codes, one-hot button codes and memory puzzle sizes
// modules reference these through bomb_pkg:: scoped names
package bomb_pkg;

    // puzzle select codes on mod_sel
    localparam logic [2:0] MOD_MOD  = 3'b000;   // module overview, no puzzle active
    localparam logic [2:0] MOD_MAZE = 3'b001;   // maze puzzle
    localparam logic [2:0] MOD_WIRE = 3'b010;   // wire puzzle
    localparam logic [2:0] MOD_MEM  = 3'b011;   // memory puzzle active

    // one-hot button codes, valid only together with strobe
    localparam logic [5:0] BTN_SELECT = 6'b000001;
    localparam logic [5:0] BTN_UP     = 6'b000010;
    localparam logic [5:0] BTN_RIGHT  = 6'b000100;
    localparam logic [5:0] BTN_DOWN   = 6'b001000;
    localparam logic [5:0] BTN_LEFT   = 6'b010000;
    localparam logic [5:0] BTN_BACK   = 6'b100000;
    localparam logic [5:0] BTN_NONE   = 6'b000000;

    // memory puzzle dimensions
    // digits and labels are 2-bit values 0..3 standing for 1..4
    localparam int NUM_STAGES = 5;              // stages per puzzle
    localparam int NUM_POS    = 4;              // button positions and label values

endpackage

/* hw/mem_cursor.sv */
// cursor over the four memory puzzle buttons
// LEFT and RIGHT move it with wrap while the memory puzzle is selected
`timescale 1ns/1ps

module mem_cursor (
    input  logic       clk,
    input  logic       nrst,
    input  logic       new_puzzle,      // back to position 0
    input  logic       strobe,          // button valid
    input  logic [5:0] button,
    input  logic [2:0] mod_sel,
    output logic [1:0] mem_pos          // currently selected position
);
    logic active;                       // press belongs to this puzzle
    logic move_right;
    logic move_left;

    assign active     = strobe && (mod_sel == bomb_pkg::MOD_MEM);
    assign move_right = active && (button == bomb_pkg::BTN_RIGHT);
    assign move_left  = active && (button == bomb_pkg::BTN_LEFT);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            mem_pos <= 2'd0;
        end else if (new_puzzle) begin
            mem_pos <= 2'd0;
        end else if (move_right) begin
            mem_pos <= mem_pos + 2'd1;  // 3 wraps to 0
        end else if (move_left) begin
            mem_pos <= mem_pos - 2'd1;  // 0 wraps to 3
        end
    end

endmodule

/* hw/mem_game.sv */
// memory puzzle subsystem of the game board
// ties generator, cursor, detector and strike tracker together
// and picks the current stage's digit and labels for the display
`timescale 1ns/1ps

module mem_game #(
    parameter logic [15:0] LFSR_SEED   = 16'hace1,
    parameter int          MAX_STRIKES = 3
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic [2:0] mod_sel,
    input  logic       new_puzzle,
    input  logic       strobe,
    input  logic [5:0] button,
    output logic [2:0] stage,
    output logic [1:0] show_digit,                      // digit of the current stage
    output logic [bomb_pkg::NUM_POS-1:0][1:0] show_labels,  // labels of the current stage
    output logic [1:0] mem_pos,
    output logic [1:0] strikes,
    output logic       mem_error,
    output logic       mem_clear,
    output logic       solved,
    output logic       lost
);
    logic [bomb_pkg::NUM_STAGES-1:0][1:0] display_num;
    logic [bomb_pkg::NUM_POS-1:0][bomb_pkg::NUM_STAGES-1:0][1:0] label_num;

    mem_puzzle_gen #(
        .LFSR_SEED (LFSR_SEED)
    ) u_mem_puzzle_gen (
        .clk         (clk),
        .nrst        (nrst),
        .new_puzzle  (new_puzzle),
        .display_num (display_num),
        .label_num   (label_num)
    );

    mem_cursor u_mem_cursor (
        .clk        (clk),
        .nrst       (nrst),
        .new_puzzle (new_puzzle),
        .strobe     (strobe),
        .button     (button),
        .mod_sel    (mod_sel),
        .mem_pos    (mem_pos)
    );

    mem_select_detector u_mem_select_detector (
        .clk         (clk),
        .nrst        (nrst),
        .mod_sel     (mod_sel),
        .new_puzzle  (new_puzzle),
        .strobe      (strobe),
        .button      (button),
        .display_num (display_num),
        .label_num   (label_num),
        .mem_pos     (mem_pos),
        .mem_error   (mem_error),
        .mem_clear   (mem_clear),
        .stage       (stage)
    );

    mem_strike_tracker #(
        .MAX_STRIKES (MAX_STRIKES)
    ) u_mem_strike_tracker (
        .clk        (clk),
        .nrst       (nrst),
        .new_puzzle (new_puzzle),
        .mem_error  (mem_error),
        .mem_clear  (mem_clear),
        .strikes    (strikes),
        .solved     (solved),
        .lost       (lost)
    );

    // display mux, stage stays within 0..4
    always_comb begin
        show_digit = display_num[stage];
        for (int p = 0; p < bomb_pkg::NUM_POS; p++) begin
            show_labels[p] = label_num[p][stage];   // label at position p
        end
    end

endmodule

/* hw/mem_puzzle_gen.sv */
// deals the memory puzzle from a free-running 16-bit LFSR
// new_puzzle registers five display digits and five label permutations
// reset loads the deal that the seed itself produces
`timescale 1ns/1ps

module mem_puzzle_gen #(
    parameter logic [15:0] LFSR_SEED = 16'hace1    // must be nonzero
) (
    input  logic clk,
    input  logic nrst,
    input  logic new_puzzle,                        // redeal strobe
    output logic [bomb_pkg::NUM_STAGES-1:0][1:0] display_num,
    output logic [bomb_pkg::NUM_POS-1:0][bomb_pkg::NUM_STAGES-1:0][1:0] label_num
);
    logic [15:0] lfsr;                              // steps every cycle
    logic        feedback;
    logic [15:0] deal_src;                          // state the deal is taken from
    logic [34:0] deal_bits;                         // 10 digit bits + 5 x 5 index bits
    logic [bomb_pkg::NUM_STAGES-1:0][1:0] nxt_display;
    logic [bomb_pkg::NUM_POS-1:0][bomb_pkg::NUM_STAGES-1:0][1:0] nxt_label;

    // widen one state into enough bits for a whole deal
    function automatic logic [34:0] spread(input logic [15:0] s);
        logic [15:0] a;
        logic [15:0] b;
        a = s ^ {s[7:0], s[15:8]};                  // byte swap mix
        b = s ^ {s[4:0], s[15:5]} ^ 16'h5a3c;       // rotate and whiten
        return {b[2:0], a, s};
    endfunction

    // k-th order of 1..4 in lexicographic sequence
    // position 0 sits in the top two bits
    function automatic logic [7:0] perm_order(input logic [4:0] k);
        case (k)
            5'd0:    perm_order = 8'b00_01_10_11;   // 1 2 3 4
            5'd1:    perm_order = 8'b00_01_11_10;   // 1 2 4 3
            5'd2:    perm_order = 8'b00_10_01_11;
            5'd3:    perm_order = 8'b00_10_11_01;
            5'd4:    perm_order = 8'b00_11_01_10;
            5'd5:    perm_order = 8'b00_11_10_01;
            5'd6:    perm_order = 8'b01_00_10_11;   // 2 1 3 4
            5'd7:    perm_order = 8'b01_00_11_10;
            5'd8:    perm_order = 8'b01_10_00_11;
            5'd9:    perm_order = 8'b01_10_11_00;
            5'd10:   perm_order = 8'b01_11_00_10;
            5'd11:   perm_order = 8'b01_11_10_00;
            5'd12:   perm_order = 8'b10_00_01_11;   // 3 1 2 4
            5'd13:   perm_order = 8'b10_00_11_01;
            5'd14:   perm_order = 8'b10_01_00_11;
            5'd15:   perm_order = 8'b10_01_11_00;
            5'd16:   perm_order = 8'b10_11_00_01;
            5'd17:   perm_order = 8'b10_11_01_00;
            5'd18:   perm_order = 8'b11_00_01_10;   // 4 1 2 3
            5'd19:   perm_order = 8'b11_00_10_01;
            5'd20:   perm_order = 8'b11_01_00_10;
            5'd21:   perm_order = 8'b11_01_10_00;
            5'd22:   perm_order = 8'b11_10_00_01;
            default: perm_order = 8'b11_10_01_00;   // 4 3 2 1
        endcase
    endfunction

    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11+1

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    assign deal_src  = nrst ? lfsr : LFSR_SEED;     // reset deals straight from the seed
    assign deal_bits = spread(deal_src);

    always_comb begin
        logic [4:0] slice;
        logic [4:0] idx;
        logic [7:0] order;
        for (int s = 0; s < bomb_pkg::NUM_STAGES; s++) begin
            nxt_display[s] = deal_bits[2*s +: 2];
            slice = deal_bits[10 + 5*s +: 5];
            idx   = (slice >= 5'd24) ? slice - 5'd24 : slice;     // modulo 24
            order = perm_order(idx);
            for (int p = 0; p < bomb_pkg::NUM_POS; p++) begin
                nxt_label[p][s] = order[2*(bomb_pkg::NUM_POS-1-p) +: 2];
            end
        end
    end

    // puzzle registers, loaded on reset and on each redeal
    always_ff @(posedge clk) begin
        if (!nrst || new_puzzle) begin
            display_num <= nxt_display;
            label_num   <= nxt_label;
        end
    end

endmodule

/* hw/mem_select_detector.sv */
// judges SELECT presses of the memory puzzle
// works out the correct position of every stage from the digits and labels
// and steps the stage, or pulses mem_clear at the last stage, or pulses mem_error
`timescale 1ns/1ps

module mem_select_detector (
    input  logic       clk,
    input  logic       nrst,
    input  logic [2:0] mod_sel,
    input  logic       new_puzzle,      // restarts at stage 0
    input  logic       strobe,
    input  logic [5:0] button,
    input  logic [bomb_pkg::NUM_STAGES-1:0][1:0] display_num,  // digit per stage
    input  logic [bomb_pkg::NUM_POS-1:0][bomb_pkg::NUM_STAGES-1:0][1:0] label_num,
    input  logic [1:0] mem_pos,         // cursor position
    output logic       mem_error,       // wrong press, same cycle as strobe
    output logic       mem_clear,       // last stage solved, same cycle as strobe
    output logic [2:0] stage
);
    logic [2:0] nxt_stage;
    logic [bomb_pkg::NUM_STAGES-1:0][1:0] right_pos;  // correct position per stage
    logic [bomb_pkg::NUM_STAGES-2:0][1:0] right_lab;  // label at that position in stages 0..3
    logic       select_press;

    // position that carries label val in stage stg
    function automatic logic [1:0] pos_of_label(
        input logic [bomb_pkg::NUM_POS-1:0][bomb_pkg::NUM_STAGES-1:0][1:0] lab,
        input int unsigned stg,
        input logic [1:0] val
    );
        logic [1:0] pos;
        pos = 2'd0;
        for (int i = 0; i < bomb_pkg::NUM_POS; i++) begin
            if (lab[i][stg] == val) begin
                pos = 2'(i);
            end
        end
        return pos;
    endfunction

    always_ff @(posedge clk) begin
        if (!nrst) begin
            stage <= 3'd0;
        end else begin
            stage <= nxt_stage;
        end
    end

    // rule table where each stage may lean on the stages before it
    always_comb begin
        right_pos = '0;
        right_lab = '0;

        case (display_num[0])
            2'd0, 2'd1: right_pos[0] = 2'd1;                // second position
            2'd2:       right_pos[0] = 2'd2;                // third position
            default:    right_pos[0] = 2'd3;                // fourth position
        endcase
        right_lab[0] = label_num[right_pos[0]][0];

        case (display_num[1])
            2'd0:    right_pos[1] = pos_of_label(label_num, 1, 2'd3);  // label 4
            2'd2:    right_pos[1] = 2'd0;                   // first position
            default: right_pos[1] = right_pos[0];           // same spot as stage 0
        endcase
        right_lab[1] = label_num[right_pos[1]][1];

        case (display_num[2])
            2'd0:    right_pos[2] = pos_of_label(label_num, 2, right_lab[1]);
            2'd1:    right_pos[2] = pos_of_label(label_num, 2, right_lab[0]);
            2'd2:    right_pos[2] = 2'd2;                   // third position
            default: right_pos[2] = pos_of_label(label_num, 2, 2'd3);  // label 4
        endcase
        right_lab[2] = label_num[right_pos[2]][2];

        case (display_num[3])
            2'd0:    right_pos[3] = right_pos[0];           // same spot as stage 0
            2'd1:    right_pos[3] = 2'd0;                   // first position
            default: right_pos[3] = right_pos[1];           // same spot as stage 1
        endcase
        right_lab[3] = label_num[right_pos[3]][3];

        // last stage repeats an earlier label
        case (display_num[4])
            2'd0:    right_pos[4] = pos_of_label(label_num, 4, right_lab[0]);
            2'd1:    right_pos[4] = pos_of_label(label_num, 4, right_lab[1]);
            2'd2:    right_pos[4] = pos_of_label(label_num, 4, right_lab[3]);
            default: right_pos[4] = pos_of_label(label_num, 4, right_lab[2]);
        endcase
    end

    assign select_press = strobe && (mod_sel == bomb_pkg::MOD_MEM)
                          && (button == bomb_pkg::BTN_SELECT);

    // redeal wins over a press in the same cycle
    always_comb begin
        mem_error = 1'b0;
        mem_clear = 1'b0;
        nxt_stage = stage;
        if (new_puzzle) begin
            nxt_stage = 3'd0;
        end else if (select_press) begin
            if (mem_pos == right_pos[stage]) begin
                if (stage == 3'(bomb_pkg::NUM_STAGES - 1)) begin
                    mem_clear = 1'b1;                       // stage holds at 4
                end else begin
                    nxt_stage = stage + 3'd1;
                end
            end else begin
                mem_error = 1'b1;                           // stage unchanged
            end
        end
    end

endmodule

/* hw/mem_strike_tracker.sv */
// strike counter of the memory puzzle
// counts errors up to MAX_STRIKES, latches solved and lost, freezes after either
`timescale 1ns/1ps

module mem_strike_tracker #(
    parameter int MAX_STRIKES = 3           // fits the 2-bit counter
) (
    input  logic       clk,
    input  logic       nrst,
    input  logic       new_puzzle,          // clears count and flags
    input  logic       mem_error,
    input  logic       mem_clear,
    output logic [1:0] strikes,
    output logic       solved,
    output logic       lost
);
    localparam logic [1:0] LAST_SAFE = 2'(MAX_STRIKES - 1);   // one more error loses

    logic done;                             // game over either way

    assign done = solved || lost;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            strikes <= 2'd0;
            solved  <= 1'b0;
            lost    <= 1'b0;
        end else if (new_puzzle) begin
            strikes <= 2'd0;
            solved  <= 1'b0;
            lost    <= 1'b0;
        end else if (!done) begin
            if (mem_clear) begin
                solved <= 1'b1;
            end else if (mem_error) begin
                strikes <= strikes + 2'd1;
                if (strikes == LAST_SAFE) begin
                    lost <= 1'b1;           // rises with the final strike
                end
            end
        end
    end

endmodule

/* list.f */
hw/bomb_pkg.sv
hw/mem_puzzle_gen.sv
hw/mem_cursor.sv
hw/mem_select_detector.sv
hw/mem_strike_tracker.sv
hw/mem_game.sv
test/tb_clock.sv
test/mem_game_checker.sv
test/mem_game_assert.sv
test/tb_mem_game.sv

/* test/mem_game_assert.sv */
// concurrent checks on the memory puzzle top
// bound to mem_game by the testbench top
`timescale 1ns/1ps

module mem_game_assert #(
    parameter int MAX_STRIKES = 3
) (
    input logic       clk,
    input logic       nrst,
    input logic       new_puzzle,
    input logic       strobe,
    input logic [5:0] button,
    input logic       mem_error,
    input logic       mem_clear,
    input logic [2:0] stage,
    input logic [1:0] strikes
);
    localparam logic [1:0] STRIKE_CAP = 2'(MAX_STRIKES);

    int   fail_count = 0;
    logic select_now;               // a SELECT press this cycle

    assign select_now = strobe && (button == bomb_pkg::BTN_SELECT);

    a_one_verdict: assert property (@(posedge clk) disable iff (!nrst)
                                    !(mem_error && mem_clear))
        else begin
            $error("mem_error and mem_clear high in the same cycle");
            fail_count++;
        end

    a_verdict_on_select: assert property (@(posedge clk) disable iff (!nrst)
                                          (mem_error || mem_clear) |-> select_now)
        else begin
            $error("verdict pulse without a SELECT strobe");
            fail_count++;
        end

    a_stage_range: assert property (@(posedge clk) disable iff (!nrst)
                                    stage <= 3'(bomb_pkg::NUM_STAGES - 1))
        else begin
            $error("stage beyond the last stage");
            fail_count++;
        end

    // count stops at the limit and never wraps until a redeal
    a_strike_range: assert property (@(posedge clk) disable iff (!nrst)
                                     (strikes == STRIKE_CAP && !new_puzzle)
                                     |=> strikes == STRIKE_CAP)
        else begin
            $error("strikes counted past the limit");
            fail_count++;
        end

endmodule

/* test/mem_game_checker.sv */
// watches the memory puzzle outputs and compares them with expected values
// the testbench top opens and closes each test through the tasks below
`timescale 1ns/1ps

module mem_game_checker (
    input  logic       clk,
    input  logic       nrst,
    input  logic       new_puzzle,
    input  logic [2:0] stage,
    input  logic [1:0] show_digit,
    input  logic [bomb_pkg::NUM_POS-1:0][1:0] show_labels,
    input  logic [1:0] mem_pos,
    input  logic [1:0] strikes,
    input  logic       mem_error,
    input  logic       mem_clear,
    input  logic       solved,
    input  logic       lost,
    output int         error_count
);
    int cmp_errs = 0;               // value mismatches
    int perm_errs = 0;              // bad label sets
    int err_pulses = 0;             // mem_error cycles seen so far
    int clr_pulses = 0;
    int base_errs;                  // snapshots at test start
    int base_err_pulses;
    int base_clr_pulses;
    int tests_run = 0;
    int tests_failed = 0;
    logic       last_valid = 1'b0;  // previous edge was out of reset
    logic       last_np;            // redeal seen at the previous edge
    logic [2:0] last_stage;
    logic [1:0] last_digit;
    logic [bomb_pkg::NUM_POS-1:0][1:0] last_labels;

    assign error_count = cmp_errs + perm_errs;

    // true when the four labels are 0..3 in some order
    function automatic logic is_perm(input logic [bomb_pkg::NUM_POS-1:0][1:0] labs);
        logic [3:0] seen;
        seen = 4'd0;
        for (int p = 0; p < bomb_pkg::NUM_POS; p++) begin
            seen[labs[p]] = 1'b1;
        end
        return seen == 4'hf;
    endfunction

    always @(posedge clk) begin
        if (nrst) begin
            if (mem_error) err_pulses++;
            if (mem_clear) clr_pulses++;
            if (!is_perm(show_labels)) begin
                $display("show_labels %h is not a permutation of 0 to 3", show_labels);
                perm_errs++;
            end
            // display holds while stage and puzzle stay put
            if (last_valid && !last_np && stage == last_stage) begin
                compare("show_digit", 8'(last_digit), 8'(show_digit));
                compare("show_labels", 8'(last_labels), 8'(show_labels));
            end
            last_valid = 1'b1;
        end else begin
            last_valid = 1'b0;
        end
        last_np     = new_puzzle;
        last_stage  = stage;
        last_digit  = show_digit;
        last_labels = show_labels;
    end

    task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
            cmp_errs++;
        end
    endtask

    task automatic start_test();
        base_errs       = error_count;
        base_err_pulses = err_pulses;
        base_clr_pulses = clr_pulses;
    endtask

    task automatic check_pos(input logic [1:0] exp);
        compare("mem_pos", 8'(exp), 8'(mem_pos));
    endtask

    // full state check and one line for the test
    task automatic end_test(input int idx, input string name, input logic [2:0] exp_stage,
                            input logic [1:0] exp_pos, input logic [1:0] exp_strikes,
                            input logic exp_solved, input logic exp_lost,
                            input int exp_err, input int exp_clr);
        compare("stage", 8'(exp_stage), 8'(stage));
        compare("mem_pos", 8'(exp_pos), 8'(mem_pos));
        compare("strikes", 8'(exp_strikes), 8'(strikes));
        compare("solved", 8'(exp_solved), 8'(solved));
        compare("lost", 8'(exp_lost), 8'(lost));
        compare("mem_error pulses", 8'(exp_err), 8'(err_pulses - base_err_pulses));
        compare("mem_clear pulses", 8'(exp_clr), 8'(clr_pulses - base_clr_pulses));
        tests_run++;
        if (error_count != base_errs) begin
            tests_failed++;
            $display("test %0d (%s) failed", idx, name);
        end else begin
            $display("test %0d (%s) ok", idx, name);
        end
    endtask

    task automatic report();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    endtask

endmodule

/* test/mem_stimulus.txt */
# columns: op arg stage strikes, stage and strikes are expected after the op
# op N new puzzle, C correct select, W wrong select, X select elsewhere, M walk arg steps
M 5 0 0
M -3 0 0
X 0 0 0
C 0 1 0
W 0 1 1
C 0 2 1
X 0 2 1
C 0 3 1
C 0 4 1
C 0 4 1
W 0 4 1
C 0 4 1
N 0 0 0
W 0 0 1
W 0 0 2
W 0 0 3
W 0 0 3
C 0 1 3
N 0 0 0
C 0 1 0
C 0 2 0
C 0 3 0
C 0 4 0
C 0 4 0

/* test/tb_clock.sv */
// clock and reset source for the memory puzzle testbench
// 4 ns period, nrst held low over the first two rising edges
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic nrst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);             // release away from the sampling edge
        nrst = 1'b1;
    end

endmodule

/* test/tb_mem_game.sv */
// testbench top for the memory puzzle subsystem
// replays test/mem_stimulus.txt, solves each stage by the game rules
// and drives all inputs on the falling clock edge
`timescale 1ns/1ps

module tb_mem_game;
    localparam int          MAX_STRIKES = 3;
    localparam logic [15:0] LFSR_SEED   = 16'hace1;

    logic       clk;
    logic       nrst;
    logic [2:0] mod_sel;
    logic       new_puzzle;
    logic       strobe;
    logic [5:0] button;
    logic [2:0] stage;
    logic [1:0] show_digit;
    logic [bomb_pkg::NUM_POS-1:0][1:0] show_labels;
    logic [1:0] mem_pos;
    logic [1:0] strikes;
    logic       mem_error;
    logic       mem_clear;
    logic       solved;
    logic       lost;
    int         error_count;

    logic [7:0]  op_q[$];           // operation letters from the file
    int          arg_q[$];
    int          stage_q[$];        // expected stage after the op
    int          strikes_q[$];      // expected strikes after the op
    int          n_ops = 0;
    logic [1:0]  model_pos;         // cursor as the testbench tracks it
    logic [2:0]  model_stage;
    logic        model_solved;
    logic [1:0]  pos_hist[bomb_pkg::NUM_STAGES];   // correct position per stage
    logic [1:0]  lab_hist[bomb_pkg::NUM_STAGES];   // label at that position
    int unsigned rnd;

    tb_clock u_tb_clock (
        .clk  (clk),
        .nrst (nrst)
    );

    mem_game #(
        .LFSR_SEED   (LFSR_SEED),
        .MAX_STRIKES (MAX_STRIKES)
    ) u_mem_game (
        .clk         (clk),
        .nrst        (nrst),
        .mod_sel     (mod_sel),
        .new_puzzle  (new_puzzle),
        .strobe      (strobe),
        .button      (button),
        .stage       (stage),
        .show_digit  (show_digit),
        .show_labels (show_labels),
        .mem_pos     (mem_pos),
        .strikes     (strikes),
        .mem_error   (mem_error),
        .mem_clear   (mem_clear),
        .solved      (solved),
        .lost        (lost)
    );

    mem_game_checker u_mem_game_checker (
        .clk         (clk),
        .nrst        (nrst),
        .new_puzzle  (new_puzzle),
        .stage       (stage),
        .show_digit  (show_digit),
        .show_labels (show_labels),
        .mem_pos     (mem_pos),
        .strikes     (strikes),
        .mem_error   (mem_error),
        .mem_clear   (mem_clear),
        .solved      (solved),
        .lost        (lost),
        .error_count (error_count)
    );

    bind mem_game mem_game_assert #(.MAX_STRIKES(MAX_STRIKES)) u_mem_game_assert (
        .clk        (clk),
        .nrst       (nrst),
        .new_puzzle (new_puzzle),
        .strobe     (strobe),
        .button     (button),
        .mem_error  (mem_error),
        .mem_clear  (mem_clear),
        .stage      (stage),
        .strikes    (strikes)
    );

    // lines starting with # are column notes
    task automatic load_stimulus();
        int         fd;
        int         got;
        string      line;
        logic [7:0] op;
        int         arg;
        int         st;
        int         sk;
        fd = $fopen("test/mem_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/mem_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got  = $fgets(line, fd);
                if (line.len() > 0 && line[0] != "#") begin
                    got = $sscanf(line, "%c %d %d %d", op, arg, st, sk);
                    if (got == 4 && (op inside {"N", "C", "W", "X", "M"})) begin
                        op_q.push_back(op);
                        arg_q.push_back(arg);
                        stage_q.push_back(st);
                        strikes_q.push_back(sk);
                    end
                end
            end
            $fclose(fd);
        end
        n_ops = op_q.size();
        if (n_ops == 0) $display("no operations could be read from the stimulus file");
    endtask

    // one strobe cycle between two falling edges
    task automatic press(input logic [5:0] btn, input logic [2:0] sel);
        mod_sel = sel;
        button  = btn;
        strobe  = 1'b1;
        @(negedge clk);
        strobe  = 1'b0;
        button  = bomb_pkg::BTN_NONE;
        mod_sel = bomb_pkg::MOD_MEM;
    endtask

    // negative steps walk left
    task automatic walk(input int steps);
        int n;
        n = (steps < 0) ? -steps : steps;
        repeat (n) begin
            if (steps < 0) begin
                press(bomb_pkg::BTN_LEFT, bomb_pkg::MOD_MEM);
                model_pos = model_pos - 2'd1;
            end else begin
                press(bomb_pkg::BTN_RIGHT, bomb_pkg::MOD_MEM);
                model_pos = model_pos + 2'd1;
            end
            u_mem_game_checker.check_pos(model_pos);    // one edge after the strobe
        end
    endtask

    task automatic move_to(input logic [1:0] target);
        while (model_pos != target) walk(1);
    endtask

    // position that shows label val
    function automatic logic [1:0] label_pos(input logic [bomb_pkg::NUM_POS-1:0][1:0] labs,
                                             input logic [1:0] val);
        logic [1:0] found;
        found = 2'd0;
        for (int p = 0; p < bomb_pkg::NUM_POS; p++) begin
            if (labs[p] == val) found = 2'(p);
        end
        return found;
    endfunction

    // memory rules with 0-based digits and labels
    function automatic logic [1:0] rule_pos(input logic [2:0] stg, input logic [1:0] d,
                                            input logic [bomb_pkg::NUM_POS-1:0][1:0] labs);
        logic [1:0] r;
        r = 2'd0;
        case (stg)
            3'd0: case (d)
                2'd0, 2'd1: r = 2'd1;
                default:    r = d;                          // digit 3 or 4 names the spot
            endcase
            3'd1: case (d)
                2'd0:    r = label_pos(labs, 2'd3);         // where the 4 sits
                2'd2:    r = 2'd0;
                default: r = pos_hist[0];
            endcase
            3'd2: case (d)
                2'd0:    r = label_pos(labs, lab_hist[1]);
                2'd1:    r = label_pos(labs, lab_hist[0]);
                2'd2:    r = 2'd2;
                default: r = label_pos(labs, 2'd3);
            endcase
            3'd3: case (d)
                2'd0:    r = pos_hist[0];
                2'd1:    r = 2'd0;
                default: r = pos_hist[1];
            endcase
            default: case (d)                               // last stage repeats a label
                2'd0:    r = label_pos(labs, lab_hist[0]);
                2'd1:    r = label_pos(labs, lab_hist[1]);
                2'd2:    r = label_pos(labs, lab_hist[3]);
                default: r = label_pos(labs, lab_hist[2]);
            endcase
        endcase
        return r;
    endfunction

    task automatic run_op(input int i);
        logic [1:0] target;
        int         exp_err;
        int         exp_clr;
        exp_err = 0;
        exp_clr = 0;
        u_mem_game_checker.start_test();
        case (op_q[i])
            "N": begin
                new_puzzle = 1'b1;
                @(negedge clk);
                new_puzzle   = 1'b0;
                model_pos    = 2'd0;
                model_solved = 1'b0;
            end
            "C": begin
                target = rule_pos(model_stage, show_digit, show_labels);
                move_to(target);
                pos_hist[model_stage] = target;
                lab_hist[model_stage] = show_labels[target];
                press(bomb_pkg::BTN_SELECT, bomb_pkg::MOD_MEM);
                if (model_stage == 3'(bomb_pkg::NUM_STAGES - 1)) begin
                    exp_clr = 1;
                    if (strikes_q[i] < MAX_STRIKES) model_solved = 1'b1;
                end
            end
            "W": begin
                target = rule_pos(model_stage, show_digit, show_labels);
                target = target + 2'd1 + 2'($urandom % 3);  // any other spot
                move_to(target);
                press(bomb_pkg::BTN_SELECT, bomb_pkg::MOD_MEM);
                exp_err = 1;
            end
            "X": begin
                press(bomb_pkg::BTN_SELECT, bomb_pkg::MOD_MAZE);
                press(bomb_pkg::BTN_RIGHT, bomb_pkg::MOD_WIRE);
                u_mem_game_checker.check_pos(model_pos);   // cursor ignores it
            end
            default: walk(arg_q[i]);
        endcase
        repeat ($urandom % 4) @(negedge clk);               // idle gap
        model_stage = 3'(stage_q[i]);
        u_mem_game_checker.end_test(i + 1, $sformatf("%c %0d", op_q[i], arg_q[i]),
                                    model_stage, model_pos, 2'(strikes_q[i]), model_solved,
                                    strikes_q[i] >= MAX_STRIKES, exp_err, exp_clr);
    endtask

    initial begin
        rnd          = $urandom(17);                        // seeds every later draw
        mod_sel      = bomb_pkg::MOD_MEM;
        new_puzzle   = 1'b0;
        strobe       = 1'b0;
        button       = bomb_pkg::BTN_NONE;
        model_pos    = 2'd0;
        model_stage  = 3'd0;
        model_solved = 1'b0;
        load_stimulus();
        wait (nrst === 1'b1);
        @(negedge clk);
        u_mem_game_checker.start_test();
        u_mem_game_checker.end_test(0, "reset", 3'd0, 2'd0, 2'd0, 1'b0, 1'b0, 0, 0);
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        u_mem_game_checker.report();
        if (n_ops > 0 && error_count == 0 && u_mem_game.u_mem_game_assert.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog allows 40 cycles of 4 ns per operation
    initial begin
        wait (n_ops > 0);
        #(n_ops * 40 * 4);
        $display("timeout: operations still running after %0d ns", n_ops * 40 * 4);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
